// ==== flist.f ====
hw/videoPkg.sv
hw/scanTiming.sv
hw/fetchControl.sv
hw/lineBuffer.sv
hw/spriteOverlay.sv
hw/paletteMap.sv
hw/mazeVideo.sv
test/mazeVideo_sva.sv
test/mazeVideoTb.sv

// ==== hw/fetchControl.sv ====
`timescale 1ns/1ps

module fetchControl (
	input logic clk,
	input logic rstN,
	input logic [9:0] hCount,
	input logic [9:0] vCount,
	input videoPkg::memWord_t memData,
	output logic [15:0] memAddr,
	output logic wrEn,
	output logic [videoPkg::bufAddrBits-1:0] wrAddr,
	output videoPkg::memWord_t wrData,
	output logic posLoad,
	output logic [2:0] posSel,
	output logic [15:0] posValue
);
	import videoPkg::*;

	logic [1:0] state;
	logic [2:0] step;
	logic [5:0] col;
	logic [6:0] sprIdx;
	logic [8:0] tgtLine; // Line being fetched.
	logic [15:0] tileId;
	logic [15:0] playerBase;
	logic [15:0] ghostBase;

	logic startTile;
	logic startRegs;
	logic [1:0] quad;
	logic [15:0] curId;
	logic [15:0] tileAddr;
	logic [15:0] bmpAddr;
	logic [15:0] sprBmpAddr;
	logic [bufAddrBits-1:0] bgWrAddr;
	logic [bufAddrBits-1:0] sprWrAddr;

	// Each read carries a tag through the two cycles until its data shows up.
	logic s1Wr, s2Wr;
	logic s1Pos, s2Pos;
	logic s1Blank, s2Blank;
	logic [bufAddrBits-1:0] s1Addr, s2Addr;
	logic [2:0] s1Sel, s2Sel;

	// Lines 0..478 fetch the next line, the last blanking line fetches line 0.
	assign startTile = (hCount == 10'd0) &&
		((vCount < vVisible - 10'd1) || (vCount == vTotal - 10'd1));
	assign startRegs = (hCount == 10'd0) && (vCount == vVisible);

	assign quad = step[1:0] - 2'd2;                           // Steps 2..5 give quads 0..3.
	assign curId = (step == 3'd2) ? memData.value : tileId; // ID used the cycle it arrives.
	assign tileAddr = tileMapBase + 16'(tgtLine[8:4]) * 16'(tileCols) + 16'(col);
	assign bmpAddr = spriteStoreBase + {curId[9:0], 6'd0} + {10'd0, tgtLine[3:0], quad};
	assign bgWrAddr = (tgtLine[0] ? bankWords : '0) + {1'b0, col, quad};

	assign sprBmpAddr = (sprIdx[6] ? ghostBase : playerBase) + {10'd0, sprIdx[5:0]};
	assign sprWrAddr = spriteAreaBase + {2'b00, sprIdx};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= fsIdle;
			step <= '0;
			col <= '0;
			sprIdx <= '0;
			memAddr <= '0;
			s1Wr <= 1'b0;
			s2Wr <= 1'b0;
			s1Pos <= 1'b0;
			s2Pos <= 1'b0;
			wrEn <= 1'b0;
			posLoad <= 1'b0;
		end else begin
			s1Wr <= 1'b0;
			s1Pos <= 1'b0;
			s2Wr <= s1Wr;
			s2Pos <= s1Pos;
			wrEn <= s2Wr;
			posLoad <= s2Pos;
			case (state)
				fsIdle: begin
					step <= '0;
					col <= '0;
					sprIdx <= '0;
					if (startTile) begin
						state <= fsTile;
					end else if (startRegs) begin
						state <= fsRegs;
					end
				end
				fsTile: begin
					if (step == 3'd0) begin
						memAddr <= tileAddr; // Tile ID read.
					end else if (step >= 3'd2) begin
						memAddr <= bmpAddr;  // Four bitmap reads.
						s1Wr <= 1'b1;
					end
					if (step == 3'd5) begin
						step <= '0;
						col <= col + 6'd1;
						if (col == 6'(tileCols - 1)) begin
							state <= fsIdle;
						end
					end else begin
						step <= step + 3'd1;
					end
				end
				fsRegs: begin
					memAddr <= playerXAddr + {13'd0, step}; // Walks X, Y, ID for both sprites.
					s1Pos <= 1'b1;
					if (step == 3'd5) begin
						step <= '0;
						state <= fsSprite;
					end else begin
						step <= step + 3'd1;
					end
				end
				fsSprite: begin
					if (!step[0]) begin
						memAddr <= sprBmpAddr;
						s1Wr <= 1'b1;
						step <= 3'd1;
					end else begin
						step <= '0;
						sprIdx <= sprIdx + 7'd1;
						if (sprIdx == 7'd127) begin
							state <= fsIdle;
						end
					end
				end
				default: state <= fsIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == fsIdle) && startTile) begin
			tgtLine <= (vCount == vTotal - 10'd1) ? 9'd0 : vCount[8:0] + 9'd1;
		end
		if ((state == fsTile) && (step == 3'd2)) begin
			tileId <= memData.value;
		end
		s1Addr <= (state == fsTile) ? bgWrAddr : sprWrAddr;
		s1Blank <= (state == fsTile) && (curId == 16'd0); // Tile 0 shows black.
		s1Sel <= step;
		s2Addr <= s1Addr;
		s2Blank <= s1Blank;
		s2Sel <= s1Sel;
		wrAddr <= s2Addr;
		wrData.value <= s2Blank ? 16'd0 : memData.value;
		posSel <= s2Sel;
		posValue <= memData.value;
		// Bitmap bases come straight from the ID words.
		if (s2Pos && (s2Sel == 3'd2)) begin
			playerBase <= spriteStoreBase + {memData.value[9:0], 6'd0};
		end
		if (s2Pos && (s2Sel == 3'd5)) begin
			ghostBase <= spriteStoreBase + {memData.value[9:0], 6'd0};
		end
	end

endmodule

// ==== hw/lineBuffer.sv ====
`timescale 1ns/1ps

module lineBuffer (
	input logic clk,
	input logic wrEn,
	input logic [videoPkg::bufAddrBits-1:0] wrAddr,
	input videoPkg::memWord_t wrData,
	input logic [videoPkg::bufAddrBits-1:0] bgAddr,
	input logic [videoPkg::bufAddrBits-1:0] sprAddr,
	output videoPkg::memWord_t bgWord,
	output videoPkg::memWord_t sprWord
);
	import videoPkg::*;

	// Words 0..159 bank 0, 160..319 bank 1.
	// Words 320..383 player bitmap, 384..447 ghost bitmap.
	memWord_t mem [bufWords];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;
		end
	end

	// Background read port.
	always_ff @(posedge clk) begin
		bgWord <= mem[bgAddr];
	end

	// Sprite read port.
	always_ff @(posedge clk) begin
		sprWord <= mem[sprAddr];
	end

endmodule

// ==== hw/mazeVideo.sv ====
`timescale 1ns/1ps

module mazeVideo (
	input logic clk,
	input logic rstN,
	output logic [15:0] memAddr,
	input videoPkg::memWord_t memData,
	output logic hSync,
	output logic vSync,
	output logic bright,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);
	import videoPkg::*;

	logic [9:0] hCount, vCount;
	logic hSyncRaw, vSyncRaw, brightRaw;
	logic hSyncD1, vSyncD1, brightD1; // First delay stage.

	logic wrEn;
	logic [bufAddrBits-1:0] wrAddr;
	memWord_t wrData;
	logic posLoad;
	logic [2:0] posSel;
	logic [15:0] posValue;

	logic [bufAddrBits-1:0] bgAddr, sprAddr;
	memWord_t bgWord, sprWord;
	colorCode_t pixelCode;

	scanTiming timing (.clk(clk), .rstN(rstN), .hCount(hCount), .vCount(vCount),
		.hSync(hSyncRaw), .vSync(vSyncRaw), .bright(brightRaw));

	fetchControl fetch (.clk(clk), .rstN(rstN), .hCount(hCount), .vCount(vCount),
		.memData(memData), .memAddr(memAddr), .wrEn(wrEn), .wrAddr(wrAddr),
		.wrData(wrData), .posLoad(posLoad), .posSel(posSel), .posValue(posValue));

	lineBuffer buffer (.clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.bgAddr(bgAddr), .sprAddr(sprAddr), .bgWord(bgWord), .sprWord(sprWord));

	spriteOverlay overlay (.clk(clk), .rstN(rstN), .hCount(hCount), .vCount(vCount),
		.posLoad(posLoad), .posSel(posSel), .posValue(posValue), .bgWord(bgWord),
		.sprWord(sprWord), .bgAddr(bgAddr), .sprAddr(sprAddr), .pixelCode(pixelCode));

	paletteMap palette (.clk(clk), .rstN(rstN), .pixelCode(pixelCode), .bright(brightD1),
		.red(red), .green(green), .blue(blue));

	// Two stages to match the buffer read and the palette register.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hSyncD1 <= 1'b1;
			vSyncD1 <= 1'b1;
			brightD1 <= 1'b0;
			hSync <= 1'b1;
			vSync <= 1'b1;
			bright <= 1'b0;
		end else begin
			hSyncD1 <= hSyncRaw;
			vSyncD1 <= vSyncRaw;
			brightD1 <= brightRaw;
			hSync <= hSyncD1;
			vSync <= vSyncD1;
			bright <= brightD1;
		end
	end

endmodule

// ==== hw/paletteMap.sv ====
`timescale 1ns/1ps

module paletteMap (
	input logic clk,
	input logic rstN,
	input videoPkg::colorCode_t pixelCode,
	input logic bright,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);
	import videoPkg::*;

	logic [23:0] rgb;

	assign rgb = paletteRgb[pixelCode];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else if (bright) begin
			red <= rgb[23:16];
			green <= rgb[15:8];
			blue <= rgb[7:0];
		end else begin
			// Black in blanking.
			red <= '0;
			green <= '0;
			blue <= '0;
		end
	end

endmodule

// ==== hw/scanTiming.sv ====
`timescale 1ns/1ps

module scanTiming (
	input logic clk,
	input logic rstN,
	output logic [9:0] hCount,
	output logic [9:0] vCount,
	output logic hSync,
	output logic vSync,
	output logic bright
);
	import videoPkg::*;

	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == hTotal - 10'd1);
	assign frameEnd = (vCount == vTotal - 10'd1);

	// Pixel counter.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
		end else begin
			hCount <= hCount + 10'd1;
		end
	end

	// Line counter, steps once per line.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			vCount <= '0;
		end else if (lineEnd) begin
			if (frameEnd) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + 10'd1;
			end
		end
	end

	// Both syncs are active low.
	assign hSync = !((hCount >= hSyncStart) && (hCount < hSyncEnd));
	assign vSync = !((vCount >= vSyncStart) && (vCount < vSyncEnd));

	assign bright = (hCount < hVisible) && (vCount < vVisible);

endmodule

// ==== hw/spriteOverlay.sv ====
`timescale 1ns/1ps

module spriteOverlay (
	input logic clk,
	input logic rstN,
	input logic [9:0] hCount,
	input logic [9:0] vCount,
	input logic posLoad,
	input logic [2:0] posSel,
	input logic [15:0] posValue,
	input videoPkg::memWord_t bgWord,
	input videoPkg::memWord_t sprWord,
	output logic [videoPkg::bufAddrBits-1:0] bgAddr,
	output logic [videoPkg::bufAddrBits-1:0] sprAddr,
	output videoPkg::colorCode_t pixelCode
);
	import videoPkg::*;

	logic [9:0] playerX, playerY;
	logic [9:0] ghostX, ghostY;
	logic [9:0] pdx, pdy;
	logic [9:0] gdx, gdy;
	logic inPlayer;
	logic inGhost;
	logic sprHit;      // Sprite word wins for this pixel.
	logic [1:0] pixIdx;

	// Positions park off the raster until the first blanking fetch.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			playerX <= hTotal;
			playerY <= vTotal;
			ghostX <= hTotal;
			ghostY <= vTotal;
		end else if (posLoad) begin
			case (posSel)
				3'd0: playerX <= posValue[9:0];
				3'd1: playerY <= posValue[9:0];
				3'd3: ghostX <= posValue[9:0];
				3'd4: ghostY <= posValue[9:0];
				default: ; // ID words only matter to the fetch side.
			endcase
		end
	end

	assign pdx = hCount - playerX;
	assign pdy = vCount - playerY;
	assign gdx = hCount - ghostX;
	assign gdy = vCount - ghostY;
	assign inPlayer = (pdx[9:4] == 6'd0) && (pdy[9:4] == 6'd0);
	assign inGhost = (gdx[9:4] == 6'd0) && (gdy[9:4] == 6'd0);

	assign bgAddr = {1'b0, hCount[9:2]} + (vCount[0] ? bankWords : '0);

	// Ghost half sits 64 words above the player half.
	assign sprAddr = inGhost ? spriteAreaBase + {3'b001, gdy[3:0], gdx[3:2]}
	                         : spriteAreaBase + {3'b000, pdy[3:0], pdx[3:2]};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			sprHit <= 1'b0;
			pixIdx <= '0;
		end else begin
			sprHit <= inGhost || inPlayer;
			pixIdx <= inGhost ? gdx[1:0] : (inPlayer ? pdx[1:0] : hCount[1:0]);
		end
	end

	assign pixelCode = sprHit ? sprWord.quad.pix[pixIdx] : bgWord.quad.pix[pixIdx];

endmodule

// ==== hw/videoPkg.sv ====
package videoPkg;

	// Tile map geometry, 16x16 pixel tiles.
	localparam int tileCols = 40;
	localparam int tileRows = 30;

	// Raster limits, one pixel per clock.
	localparam logic [9:0] hVisible = 10'(tileCols * 16);
	localparam logic [9:0] hSyncStart = 10'd656;
	localparam logic [9:0] hSyncEnd = 10'd752;
	localparam logic [9:0] hTotal = 10'd800;
	localparam logic [9:0] vVisible = 10'(tileRows * 16);
	localparam logic [9:0] vSyncStart = 10'd490;
	localparam logic [9:0] vSyncEnd = 10'd492;
	localparam logic [9:0] vTotal = 10'd525;

	// External memory map.
	localparam logic [15:0] tileMapBase = 16'h1000;     // Row-major, one ID per word.
	localparam logic [15:0] spriteStoreBase = 16'h14B0; // 64 words per ID.
	localparam logic [15:0] playerXAddr = 16'h1C30;
	localparam logic [15:0] playerYAddr = 16'h1C31;
	localparam logic [15:0] playerIdAddr = 16'h1C32;
	localparam logic [15:0] ghostXAddr = 16'h1C33;
	localparam logic [15:0] ghostYAddr = 16'h1C34;
	localparam logic [15:0] ghostIdAddr = 16'h1C35;

	// Line buffer layout: two background banks, then player and ghost bitmaps.
	localparam int bufAddrBits = 9;
	localparam int bufWords = 448;
	localparam logic [bufAddrBits-1:0] bankWords = bufAddrBits'(tileCols * 4);
	localparam logic [bufAddrBits-1:0] spriteAreaBase = 9'd320;

	// Fetch sequencer states.
	localparam logic [1:0] fsIdle = 2'd0;
	localparam logic [1:0] fsTile = 2'd1;
	localparam logic [1:0] fsRegs = 2'd2;
	localparam logic [1:0] fsSprite = 2'd3;

	typedef logic [2:0] colorCode_t;

	// One memory word, read either as a number or as four pixels.
	typedef union packed {
		logic [15:0] value;
		struct packed {
			logic [1:0] padHi;
			colorCode_t [0:3] pix; // Pixel 0 sits in bits 13:11.
			logic [1:0] padLo;
		} quad;
	} memWord_t;

	// RGB for each colour code, index 0 first.
	localparam logic [0:7][23:0] paletteRgb = {
		24'h000000, // Black.
		24'h639BFF, // Blue.
		24'hFBF236, // Yellow.
		24'hFF3232, // Red.
		24'hAC3232, // Crimson.
		24'h000000,
		24'h000000,
		24'hFFFFFF  // White.
	};

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the testbench and the design with Verilator, then runs the simulation.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module mazeVideoTb -f flist.f -o mazeVideoSim

# An assertion stop also counts as a failure, since the pass line never appears.
output=$(./obj_dir/mazeVideoSim || true)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Verification passed"

// ==== test/mazeVideoTb.sv ====
`timescale 1ns/1ps

module mazeVideoTb;
	import videoPkg::*;

	localparam int frameTimeout = 800 * 525 + 2000;

	logic clk;
	logic rstN;
	logic [15:0] memAddr;
	memWord_t memData = '0;
	logic hSync, vSync, bright;
	logic [7:0] red, green, blue;

	logic [15:0] mem [65536];
	logic [15:0] addrQ = '0;
	logic [31:0] lfsrState;
	bit timedOut = 1'b0;
	int rgbErrors = 0;
	int syncErrors = 0;
	int timingErrors = 0;

	// Output raster position, recovered from bright and vSync.
	int col = 0;
	int row = 0;
	int hCycles = 0;
	int lineCount = 0;
	int frameNo = 0;
	logic prevHs = 1'b1;
	logic prevVs = 1'b1;
	logic prevBright = 1'b0;
	logic wasReset = 1'b1;
	logic [23:0] expRgb;

	mazeVideo DUT (.clk(clk), .rstN(rstN), .memAddr(memAddr), .memData(memData),
		.hSync(hSync), .vSync(vSync), .bright(bright), .red(red), .green(green), .blue(blue));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Word memory with one cycle of read latency.
	always @(negedge clk) begin
		memData.value <= mem[addrQ];
		addrQ <= memAddr;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[14:0], lfsrState[0]};
		end
	endtask

	task automatic fillMemory();
		logic [15:0] bits;
		for (int a = 0; a < 65536; a++) begin
			mem[16'(a)] = 16'(a * 40503) ^ 16'hC3A5;
		end
		for (int t = 0; t < tileCols * tileRows; t++) begin
			drawBits(3, bits); // IDs 0..7, so about one tile in eight is blank.
			mem[tileMapBase + 16'(t)] = bits;
		end
		for (int w = 64; w < 8 * 64; w++) begin
			drawBits(16, bits);
			mem[spriteStoreBase + 16'(w)] = bits;
		end
		// Boxes overlap by 8x8 and straddle the tile edge at x 160.
		mem[playerXAddr] = 16'd150;
		mem[playerYAddr] = 16'd92;
		drawBits(3, bits);
		mem[playerIdAddr] = (bits == 16'd0) ? 16'd7 : bits;
		mem[ghostXAddr] = 16'd158;
		mem[ghostYAddr] = 16'd100;
		drawBits(3, bits);
		mem[ghostIdAddr] = (bits == 16'd0) ? 16'd5 : bits;
	endtask

	function automatic logic [23:0] paletteOf(input logic [2:0] code);
		case (code)
			3'd1: return 24'h639BFF;
			3'd2: return 24'hFBF236;
			3'd3: return 24'hFF3232;
			3'd4: return 24'hAC3232;
			3'd7: return 24'hFFFFFF;
			default: return 24'h000000;
		endcase
	endfunction

	// Pixel 0 sits in bits 13:11, pixel 3 in bits 4:2.
	function automatic logic [2:0] bitmapCode(input logic [15:0] id, input int dx, input int dy);
		logic [15:0] word;
		word = mem[spriteStoreBase + 16'(id * 64 + dy * 4 + dx / 4)];
		return 3'(word >> (11 - 3 * (dx % 4)));
	endfunction

	function automatic logic [23:0] expectedRgb(input int h, input int v);
		int px, py, gx, gy;
		logic [15:0] tile;
		px = h - int'(mem[playerXAddr]);
		py = v - int'(mem[playerYAddr]);
		gx = h - int'(mem[ghostXAddr]);
		gy = v - int'(mem[ghostYAddr]);
		if ((gx >= 0) && (gx < 16) && (gy >= 0) && (gy < 16)) begin
			return paletteOf(bitmapCode(mem[ghostIdAddr], gx, gy));
		end
		if ((px >= 0) && (px < 16) && (py >= 0) && (py < 16)) begin
			return paletteOf(bitmapCode(mem[playerIdAddr], px, py));
		end
		tile = mem[tileMapBase + 16'((v / 16) * tileCols + h / 16)];
		if (tile == 16'd0) begin
			return 24'h000000;
		end
		return paletteOf(bitmapCode(tile, h % 16, v % 16));
	endfunction

	task automatic checkRgb(input string testName, input logic [7:0] expR, input logic [7:0] expG,
		input logic [7:0] expB, input logic [7:0] actR, input logic [7:0] actG,
		input logic [7:0] actB);
		if ({actR, actG, actB} !== {expR, expG, expB}) begin
			rgbErrors++;
			$display("CHECK FAILED %s: expected %h, actual %h", testName,
				{expR, expG, expB}, {actR, actG, actB});
		end
	endtask

	// Levels are shown as {hSync, vSync}.
	task automatic checkSync(input string testName, input logic expHs, input logic expVs,
		input logic actHs, input logic actVs);
		if ({actHs, actVs} !== {expHs, expVs}) begin
			syncErrors++;
			$display("CHECK FAILED %s: expected %b, actual %b", testName,
				{expHs, expVs}, {actHs, actVs});
		end
	endtask

	task automatic checkPeriod(input string testName, input int expected, input int actual);
		if (actual != expected) begin
			timingErrors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", testName, expected, actual);
		end
	endtask

	always @(negedge clk) begin
		if (!rstN) begin
			checkSync("sync in reset", 1'b1, 1'b1, hSync, vSync);
			checkRgb("rgb in reset", 8'd0, 8'd0, 8'd0, red, green, blue);
		end else begin
			if (wasReset) begin
				checkSync("sync after reset", 1'b1, 1'b1, hSync, vSync);
				checkRgb("rgb after reset", 8'd0, 8'd0, 8'd0, red, green, blue);
			end
			hCycles++;
			if (prevHs && !hSync) begin
				if (frameNo >= 2) begin
					checkPeriod("clocks per line", 800, hCycles);
				end
				hCycles = 0;
				lineCount++;
			end
			if (prevVs && !vSync) begin
				if (frameNo >= 2) begin
					checkPeriod("lines per frame", 525, lineCount);
					checkPeriod("visible lines", 480, row);
				end
				lineCount = 0;
				row = 0;
				frameNo++;
			end
			if ((frameNo == 2) || (frameNo == 3)) begin
				if (bright) begin
					expRgb = expectedRgb(col, row);
					checkRgb($sformatf("frame %0d pixel (%0d,%0d)", frameNo, col, row),
						expRgb[23:16], expRgb[15:8], expRgb[7:0], red, green, blue);
				end else begin
					checkRgb($sformatf("frame %0d blanking", frameNo), 8'd0, 8'd0, 8'd0,
						red, green, blue);
				end
			end
			if (bright) begin
				col++;
			end else if (prevBright) begin
				if ((frameNo == 2) || (frameNo == 3)) begin
					checkPeriod("pixels per line", 640, col);
				end
				col = 0;
				row++;
			end
		end
		wasReset = !rstN;
		prevHs = hSync;
		prevVs = vSync;
		prevBright = bright;
	end

	task automatic waitFrame(input int target);
		int waited;
		waited = 0;
		while ((frameNo < target) && (waited < frameTimeout)) begin
			@(posedge clk);
			waited++;
		end
		if (frameNo < target) begin
			timedOut = 1'b1;
			$display("Timeout: vSync did not fall for frame %0d within %0d clocks", target,
				frameTimeout);
		end
	endtask

	initial begin
		rstN = 1'b0;
		lfsrState = 32'he584;
		fillMemory();
		repeat (8) @(negedge clk);
		rstN <= 1'b1;
		// The fourth vSync fall closes frame 3.
		for (int f = 1; (f <= 4) && !timedOut; f++) begin
			waitFrame(f);
		end
		$display("Errors: %0d pixel, %0d sync level, %0d timing, %0d timeout", rgbErrors,
			syncErrors, timingErrors, timedOut ? 1 : 0);
		if (!timedOut && (rgbErrors + syncErrors + timingErrors == 0)) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== test/mazeVideo_sva.sv ====
`timescale 1ns/1ps

module mazeVideoSva (
	input logic clk,
	input logic rstN,
	input logic [15:0] memAddr,
	input logic hSync,
	input logic bright,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);

	logic [6:0] lowRun;      // Clocks that hSync has been low.
	logic [1:0] resetCycles; // Clocks spent in reset, saturating.

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lowRun <= '0;
		end else if (hSync) begin
			lowRun <= '0;
		end else begin
			lowRun <= lowRun + 7'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rstN) begin
			resetCycles <= '0;
		end else if (resetCycles != 2'd3) begin
			resetCycles <= resetCycles + 2'd1;
		end
	end

	// Aligned blanking comes out black.
	blankIsBlack: assert property (@(posedge clk) disable iff (!rstN)
		!bright |-> ((red == 8'd0) && (green == 8'd0) && (blue == 8'd0)))
		else $error("RGB is not zero while bright is low");

	// Sync pulse is 96 pixel clocks wide.
	hSyncWidth: assert property (@(posedge clk) disable iff (!rstN)
		$rose(hSync) |-> (lowRun == 7'd96))
		else $error("hSync pulse width is %0d clocks", lowRun);

	resetAddrStable: assert property (@(posedge clk)
		(!rstN && (resetCycles >= 2'd2)) |-> $stable(memAddr))
		else $error("memAddr moved during reset");

endmodule

bind mazeVideo mazeVideoSva checks (
	.clk(clk),
	.rstN(rstN),
	.memAddr(memAddr),
	.hSync(hSync),
	.bright(bright),
	.red(red),
	.green(green),
	.blue(blue)
);
